// ==== sim/forth_search_assertions.sv ====
//**************************************************************************
// concurrent checks on dispatch, lane occupancy and in-order drain
//**************************************************************************
module forth_search_assertions import forth_search_pkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic                 full,
    input logic [NUM_LANES-1:0] lane_start,
    input logic [NUM_LANES-1:0] lane_busy,
    input logic [NUM_LANES-1:0] lane_done,
    input logic [NUM_LANES-1:0] lane_pop
);

    // a lane takes a new search only when it is free
    no_start_to_busy: assert property (@(posedge clk) disable iff (reset)
        (lane_start & lane_busy) == '0)
        else $error("start pulsed to a busy lane");

    // a popped lane drops its result, so it cannot feed res_valid twice
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_pop
        single_drain: assert property (@(posedge clk) disable iff (reset)
            lane_pop[i] |=> !lane_done[i])
            else $error("lane %0d still shows done after its pop", i);
    end

    full_after_reset: assert property (@(posedge clk) reset |=> !full)
        else $error("full high right after reset");

endmodule

bind forth_search_top forth_search_assertions assertions_inst (
    .clk        (clk),
    .reset      (reset),
    .full       (full),
    .lane_start (lane_start),
    .lane_busy  (lane_busy),
    .lane_done  (lane_done),
    .lane_pop   (lane_pop)
);

// ==== sim/tb_forth_search.sv ====
//**************************************************************************
// testbench for the dictionary search engine: clock, reset, loader,
// lookup table with expected results, in-order scoreboard
//**************************************************************************
module tb_forth_search import forth_search_pkg::*; ();

    localparam int NUM_REQ     = 17;
    localparam int FULL_LIMIT  = 200;     // cycles to wait for a free lane
    localparam int DRAIN_LIMIT = 2000;    // cycles to wait for the last results
    localparam logic [15:0] LFSR_SEED = 16'd27911;

    // header = lfa lo, lfa hi, length, name bytes
    localparam logic [DICT_ADDR_W-1:0] DUP_HDR  = 12'h100;
    localparam logic [DICT_ADDR_W-1:0] DROP_HDR = DUP_HDR + 12'd6;    // 3 + "DUP"
    localparam logic [DICT_ADDR_W-1:0] SWAP_HDR = DROP_HDR + 12'd7;   // 3 + "DROP"
    localparam logic [DICT_ADDR_W-1:0] OVER_HDR = SWAP_HDR + 12'd7;   // 3 + "SWAP"
    localparam logic [DICT_ADDR_W-1:0] ROT_HDR  = OVER_HDR + 12'd7;   // 3 + "OVER"
    localparam logic [DICT_ADDR_W-1:0] TIB_BASE = 12'h400;

    typedef struct packed {
        logic [DICT_ADDR_W-1:0] tib;
        logic [DICT_ADDR_W-1:0] ctx;
        logic                   hit;
        logic [DICT_ADDR_W-1:0] word;      // only checked on a hit
        logic [DICT_ADDR_W-1:0] next_tib;
        logic                   burst;     // no idle gap before this one
    } lookup_entry;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   wr_en;
    logic [DICT_ADDR_W-1:0] wr_addr;
    logic [7:0]             wr_data;
    logic                   req;
    logic [DICT_ADDR_W-1:0] req_tib;
    logic [DICT_ADDR_W-1:0] req_ctx;
    logic                   full;
    logic                   res_valid;
    logic                   res_hit;
    logic [DICT_ADDR_W-1:0] res_word;
    logic [DICT_ADDR_W-1:0] res_next_tib;

    lookup_entry lookups [NUM_REQ];
    int          rd_idx    = 0;           // next expected result
    int          errors    = 0;
    int          timeouts  = 0;
    logic        full_seen = 1'b0;
    logic [15:0] lfsr;

    forth_search_top forth_search_top_inst (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .req          (req),
        .req_tib      (req_tib),
        .req_ctx      (req_ctx),
        .full         (full),
        .res_valid    (res_valid),
        .res_hit      (res_hit),
        .res_word     (res_word),
        .res_next_tib (res_next_tib)
    );

    always #4 clk = ~clk;    // period 8

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic write_byte(input logic [DICT_ADDR_W-1:0] addr, input logic [7:0] data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);      // written on the rising edge in between
        wr_en   = 1'b0;
    endtask

    task automatic write_word(input logic [DICT_ADDR_W-1:0] hdr,
                              input logic [DICT_ADDR_W-1:0] link, input string name);
        write_byte(hdr, link[7:0]);                  // lfa, low byte first
        write_byte(hdr + 12'd1, {4'h0, link[11:8]});
        write_byte(hdr + 12'd2, 8'(name.len()));
        for (int i = 0; i < name.len(); i++) begin
            write_byte(hdr + 12'd3 + 12'(i), name[i]);
        end
    endtask

    task automatic load_dictionary();
        string tib_text;
        // offsets: ROT 0, DUP 4, NIP 8, DRO 12, DROPX 16, spaces 21..24, SWAP 25,
        // OVER 30, DROP 35; every token ends in a space
        tib_text = "ROT DUP NIP DRO DROPX    SWAP OVER DROP ";
        write_word(DUP_HDR,  LINK_END, "DUP");
        write_word(DROP_HDR, DUP_HDR,  "DROP");
        write_word(SWAP_HDR, DROP_HDR, "SWAP");
        write_word(OVER_HDR, SWAP_HDR, "OVER");
        write_word(ROT_HDR,  OVER_HDR, "ROT");    // newest word, the usual context
        for (int i = 0; i < tib_text.len(); i++) begin
            write_byte(TIB_BASE + 12'(i), tib_text[i]);
        end
    endtask

    // hit: next_tib is the delimiting space; miss: the token start after spaces
    task automatic set_entry(input int idx, input int tib_off,
                             input logic [DICT_ADDR_W-1:0] ctx, input logic hit,
                             input logic [DICT_ADDR_W-1:0] word, input int next_off,
                             input logic burst);
        lookups[idx].tib      = TIB_BASE + 12'(tib_off);
        lookups[idx].ctx      = ctx;
        lookups[idx].hit      = hit;
        lookups[idx].word     = word;
        lookups[idx].next_tib = TIB_BASE + 12'(next_off);
        lookups[idx].burst    = burst;
    endtask

    task automatic fill_lookups();
        set_entry(0,  0,  ROT_HDR,  1'b1, ROT_HDR,  3,  1'b0);   // word at the head
        set_entry(1,  4,  ROT_HDR,  1'b1, DUP_HDR,  7,  1'b0);   // oldest word
        set_entry(2,  8,  ROT_HDR,  1'b0, '0,       8,  1'b0);   // NIP, absent
        set_entry(3,  12, ROT_HDR,  1'b0, '0,       12, 1'b0);   // DRO, prefix
        set_entry(4,  16, ROT_HDR,  1'b0, '0,       16, 1'b0);   // DROPX, too long
        set_entry(5,  22, ROT_HDR,  1'b1, SWAP_HDR, 29, 1'b0);   // three spaces first
        set_entry(6,  30, ROT_HDR,  1'b1, OVER_HDR, 34, 1'b0);
        set_entry(7,  35, ROT_HDR,  1'b1, DROP_HDR, 39, 1'b0);
        set_entry(8,  0,  OVER_HDR, 1'b0, '0,       0,  1'b0);   // ROT newer than ctx
        set_entry(9,  21, SWAP_HDR, 1'b1, SWAP_HDR, 29, 1'b0);   // four spaces first
        set_entry(10, 4,  ROT_HDR,  1'b1, DUP_HDR,  7,  1'b1);   // burst from here
        set_entry(11, 0,  ROT_HDR,  1'b1, ROT_HDR,  3,  1'b1);
        set_entry(12, 8,  ROT_HDR,  1'b0, '0,       8,  1'b1);
        set_entry(13, 35, ROT_HDR,  1'b1, DROP_HDR, 39, 1'b1);
        set_entry(14, 25, DROP_HDR, 1'b0, '0,       25, 1'b1);   // SWAP newer than ctx
        set_entry(15, 30, OVER_HDR, 1'b1, OVER_HDR, 34, 1'b1);
        set_entry(16, 4,  DUP_HDR,  1'b1, DUP_HDR,  7,  1'b1);   // one-word list
    endtask

    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr);           // one step per bit
            gap  = (gap << 1) | lfsr[0];
        end
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_lookup(input int n);
        int cnt;
        cnt = 0;
        while (full && cnt < FULL_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (full) begin
            timeouts++;
            $display("timed out waiting for a free lane before request %0d", n);
        end else begin
            req     = 1'b1;
            req_tib = lookups[n].tib;
            req_ctx = lookups[n].ctx;
            @(negedge clk);                   // accepted on the edge in between
            req     = 1'b0;
        end
    endtask

    // scoreboard, results come back in request order
    always @(negedge clk) begin
        if (!reset) begin
            if (full) full_seen = 1'b1;
            if (res_valid) begin
                if (rd_idx >= NUM_REQ) begin
                    errors++;
                    $display("result strobe with no request outstanding");
                end else begin
                    check_value($sformatf("res_hit[%0d]", rd_idx), 32'(res_hit),
                                32'(lookups[rd_idx].hit));
                    if (lookups[rd_idx].hit) begin
                        check_value($sformatf("res_word[%0d]", rd_idx), 32'(res_word),
                                    32'(lookups[rd_idx].word));
                    end
                    check_value($sformatf("res_next_tib[%0d]", rd_idx),
                                32'(res_next_tib), 32'(lookups[rd_idx].next_tib));
                    rd_idx++;
                end
            end
        end
    end

    initial begin
        int cnt;
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        req     = 1'b0;
        req_tib = '0;
        req_ctx = '0;
        lfsr    = LFSR_SEED;
        fill_lookups();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        load_dictionary();
        for (int n = 0; n < NUM_REQ && timeouts == 0; n++) begin
            if (!lookups[n].burst) idle_gap();
            send_lookup(n);
        end
        cnt = 0;
        while (rd_idx < NUM_REQ && timeouts == 0 && cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (rd_idx < NUM_REQ && timeouts == 0) begin
            timeouts++;
            $display("timed out waiting for results, %0d of %0d received", rd_idx, NUM_REQ);
        end
        if (!full_seen && timeouts == 0) begin
            errors++;
            $display("full never rose during the request burst");
        end
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/forth_search_pkg.sv
verilog/dict_ram.sv
verilog/finder.sv
verilog/search_lane.sv
verilog/lookup_dispatch.sv
verilog/result_collect.sv
verilog/forth_search_top.sv
sim/forth_search_assertions.sv
sim/tb_forth_search.sv

// ==== verilog/dict_ram.sv ====
//**************************************************************************
// byte memory, one write port and one registered read port
//**************************************************************************
module dict_ram import forth_search_pkg::*; (
    input  logic                   clk,
    input  logic                   wr_en,     // loader strobe
    input  logic [DICT_ADDR_W-1:0] wr_addr,
    input  logic [7:0]             wr_data,
    input  logic [DICT_ADDR_W-1:0] rd_addr,   // from the finder
    output logic [7:0]             rd_data    // valid one cycle after rd_addr
);

    logic [7:0] mem [DICT_BYTES];    // headers and tib text share this space

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;    // loader writes every lane copy at once
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];        // read is independent of the write
    end

endmodule

// ==== verilog/finder.sv ====
//**************************************************************************
// dictionary word finder FSM for one search lane
// walks the header chain from the context and compares names with the tib
//**************************************************************************
module finder import forth_search_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,      // one-cycle request strobe
    input  logic [DICT_ADDR_W-1:0] tib_in,     // token address in the tib
    input  logic [DICT_ADDR_W-1:0] ctx,        // newest header address
    output logic [DICT_ADDR_W-1:0] rd_addr,
    input  logic [7:0]             rd_data,    // data for last cycle's rd_addr
    output logic                   busy,
    output logic                   done,       // one-cycle pulse at the end
    output logic                   hit,
    output logic [DICT_ADDR_W-1:0] word_addr,  // header of the matched word
    output logic [DICT_ADDR_W-1:0] next_tib
);

    finder_state state, state_nxt;

    logic [DICT_ADDR_W-1:0] hdr;        // header being checked
    logic [DICT_ADDR_W-1:0] link;       // its link field
    logic [7:0]             link_lo;
    logic [DICT_ADDR_W-1:0] a0;         // header / name pointer
    logic [DICT_ADDR_W-1:0] a0n;        // one past the last name byte
    logic [DICT_ADDR_W-1:0] a1;         // tib pointer
    logic [DICT_ADDR_W-1:0] tib_start;  // first non-space of the token
    logic [7:0]             name_byte;  // expected byte for the next CMP
    logic                   term;       // name_byte is the trailing space
    logic                   skip;       // still in the leading-space scan

    logic is_space;
    logic byte_eq;
    logic last_word;

    assign is_space  = (rd_data == CHAR_SPACE);
    assign byte_eq   = (rd_data == name_byte);
    assign last_word = (link == LINK_END);

    always_ff @(posedge clk) begin
        if (reset) state <= FD0;
        else       state <= state_nxt;
    end

    always_comb begin
        case (state)
            FD0: state_nxt = start ? LF0 : FD0;
            LF0: state_nxt = (skip && is_space) ? SPC : LF1;
            SPC: state_nxt = LF0;
            LF1: state_nxt = LEN;
            LEN: state_nxt = NFA;
            NFA: state_nxt = TIB;
            TIB: state_nxt = CMP;
            CMP: begin
                if (!byte_eq)  state_nxt = last_word ? FD0 : LF0;  // miss, next word
                else if (term) state_nxt = FD0;                     // full match
                else           state_nxt = TIB;
            end
            default: state_nxt = FD0;
        endcase
    end

    // address mux, one read per state
    always_comb begin
        case (state)
            FD0:     rd_addr = tib_in;  // first token byte, checked in LF0
            SPC:     rd_addr = a1;      // next tib byte after a space
            TIB:     rd_addr = a1;
            default: rd_addr = a0;      // header and name bytes
        endcase
    end

    always_ff @(posedge clk) begin
        done <= 1'b0;                   // pulse only
        case (state)
            FD0: begin
                if (start) begin
                    hdr  <= ctx;
                    a0   <= ctx;
                    a1   <= tib_in;
                    skip <= 1'b1;
                    busy <= 1'b1;
                end
            end
            LF0: begin
                if (skip && is_space) begin
                    a1 <= a1 + 1'b1;            // leading space
                end else begin
                    a0   <= a0 + 1'b1;          // lfa high byte next
                    skip <= 1'b0;
                    if (skip) tib_start <= a1;  // token start, kept for rewinds
                end
            end
            LF1: begin
                link_lo <= rd_data;
                a0      <= a0 + 1'b1;           // length byte next
            end
            LEN: begin
                link <= {rd_data[DICT_ADDR_W-9:0], link_lo};
                a0   <= a0 + 1'b1;              // first name byte
            end
            NFA: a0n <= a0 + DICT_ADDR_W'(rd_data);
            TIB: begin
                term      <= (a0 == a0n);        // past the name, expect a space
                name_byte <= (a0 == a0n) ? CHAR_SPACE : rd_data;
                a0        <= a0 + 1'b1;
            end
            CMP: begin
                if (!byte_eq) begin
                    if (last_word) begin
                        busy     <= 1'b0;        // end of list, miss
                        done     <= 1'b1;
                        hit      <= 1'b0;
                        next_tib <= tib_start;   // no scan to the token end on a miss
                    end else begin
                        hdr <= link;             // follow the link
                        a0  <= link;
                        a1  <= tib_start;        // rewind the token
                    end
                end else if (term) begin
                    busy      <= 1'b0;
                    done      <= 1'b1;
                    hit       <= 1'b1;
                    word_addr <= hdr;
                    next_tib  <= a1;             // the delimiting space
                end else begin
                    a1 <= a1 + 1'b1;
                end
            end
            default: ;                           // SPC only presents a1
        endcase
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            hit  <= 1'b0;
        end
    end

endmodule

// ==== verilog/forth_search_pkg.sv ====
//**************************************************************************
// shared constants for the dictionary search engine
// and the state encoding of the word finder
//**************************************************************************
package forth_search_pkg;

    localparam int DICT_ADDR_W = 12;                 // byte address width
    localparam int DICT_BYTES  = 1 << DICT_ADDR_W;   // 4K dictionary + tib space
    localparam int NUM_LANES   = 4;                  // parallel finders
    localparam int LANE_W      = 2;                  // lane index width

    localparam logic [DICT_ADDR_W-1:0] LINK_END = '1;  // lfa of 0xfff ends the list
    localparam logic [7:0] CHAR_SPACE = 8'h20;         // token delimiter

    // finder states; rd_data in each state belongs to the address of the one before
    typedef enum logic [2:0] {
        FD0,    // idle, waiting for start
        LF0,    // present lfa low, skip tib spaces
        LF1,    // present lfa high, take low byte
        LEN,    // present length byte, take high byte
        NFA,    // present first name byte, take length
        TIB,    // present tib byte, take name byte
        CMP,    // compare, present next name byte
        SPC     // step past a leading space
    } finder_state;

endpackage

// ==== verilog/forth_search_top.sv ====
//**************************************************************************
// parallel dictionary search engine top level
// dispatcher, NUM_LANES search lanes, in-order collector
//**************************************************************************
module forth_search_top import forth_search_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_en,         // dictionary loader
    input  logic [DICT_ADDR_W-1:0] wr_addr,
    input  logic [7:0]             wr_data,
    input  logic                   req,           // lookup strobe
    input  logic [DICT_ADDR_W-1:0] req_tib,
    input  logic [DICT_ADDR_W-1:0] req_ctx,
    output logic                   full,
    output logic                   res_valid,
    output logic                   res_hit,
    output logic [DICT_ADDR_W-1:0] res_word,
    output logic [DICT_ADDR_W-1:0] res_next_tib
);

    logic [NUM_LANES-1:0]                  lane_busy;
    logic [NUM_LANES-1:0]                  lane_start;
    logic [NUM_LANES-1:0]                  lane_done;
    logic [NUM_LANES-1:0]                  lane_pop;
    logic [NUM_LANES-1:0]                  lane_hit;
    logic [NUM_LANES-1:0][DICT_ADDR_W-1:0] lane_word;
    logic [NUM_LANES-1:0][DICT_ADDR_W-1:0] lane_next_tib;

    lookup_dispatch dispatch_inst (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .lane_busy (lane_busy),
        .start     (lane_start),
        .full      (full)
    );

    // request fields go to every lane, start picks the one that loads them
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        search_lane lane_inst (
            .clk       (clk),
            .reset     (reset),
            .start     (lane_start[i]),
            .tib_in    (req_tib),
            .ctx       (req_ctx),
            .wr_en     (wr_en),
            .wr_addr   (wr_addr),
            .wr_data   (wr_data),
            .busy      (lane_busy[i]),
            .done      (lane_done[i]),
            .pop       (lane_pop[i]),
            .hit       (lane_hit[i]),
            .word_addr (lane_word[i]),
            .next_tib  (lane_next_tib[i])
        );
    end

    result_collect collect_inst (
        .clk           (clk),
        .reset         (reset),
        .lane_done     (lane_done),
        .lane_hit      (lane_hit),
        .lane_word     (lane_word),
        .lane_next_tib (lane_next_tib),
        .pop           (lane_pop),
        .res_valid     (res_valid),
        .res_hit       (res_hit),
        .res_word      (res_word),
        .res_next_tib  (res_next_tib)
    );

endmodule

// ==== verilog/lookup_dispatch.sv ====
//**************************************************************************
// round-robin request dispatcher, one start per accepted request
//**************************************************************************
module lookup_dispatch import forth_search_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,         // request strobe
    input  logic [NUM_LANES-1:0] lane_busy,
    output logic [NUM_LANES-1:0] start,
    output logic                 full         // lane at the pointer not free
);

    logic [LANE_W-1:0] next_lane;
    logic              accept;

    assign full   = lane_busy[next_lane];
    assign accept = req & ~full;              // req during full is dropped

    always_comb begin
        start            = '0;
        start[next_lane] = accept;            // same cycle as req
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            next_lane <= '0;
        end else if (accept) begin
            if (next_lane == LANE_W'(NUM_LANES - 1)) next_lane <= '0;
            else                                     next_lane <= next_lane + 1'b1;
        end
    end

endmodule

// ==== verilog/result_collect.sv ====
//**************************************************************************
// in-order result collector, drains lanes in round-robin order
//**************************************************************************
module result_collect import forth_search_pkg::*; (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [NUM_LANES-1:0]                  lane_done,
    input  logic [NUM_LANES-1:0]                  lane_hit,
    input  logic [NUM_LANES-1:0][DICT_ADDR_W-1:0] lane_word,
    input  logic [NUM_LANES-1:0][DICT_ADDR_W-1:0] lane_next_tib,
    output logic [NUM_LANES-1:0]                  pop,
    output logic                                  res_valid,
    output logic                                  res_hit,
    output logic [DICT_ADDR_W-1:0]                res_word,
    output logic [DICT_ADDR_W-1:0]                res_next_tib
);

    logic [LANE_W-1:0] drain_ptr;    // follows the dispatch order
    logic              take;

    assign take = lane_done[drain_ptr];   // later lanes wait with done held

    always_comb begin
        pop            = '0;
        pop[drain_ptr] = take;            // lane drops done on this edge
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            drain_ptr <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= take;
            if (take) begin
                if (drain_ptr == LANE_W'(NUM_LANES - 1)) drain_ptr <= '0;
                else                                     drain_ptr <= drain_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_hit      <= lane_hit[drain_ptr];
            res_word     <= lane_word[drain_ptr];
            res_next_tib <= lane_next_tib[drain_ptr];
        end
    end

endmodule

// ==== verilog/search_lane.sv ====
//**************************************************************************
// one search lane: finder, private dict_ram copy, result hold registers
//**************************************************************************
module search_lane import forth_search_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [DICT_ADDR_W-1:0] tib_in,
    input  logic [DICT_ADDR_W-1:0] ctx,
    input  logic                   wr_en,
    input  logic [DICT_ADDR_W-1:0] wr_addr,
    input  logic [7:0]             wr_data,
    output logic                   busy,      // searching or holding a result
    output logic                   done,      // result waiting for the collector
    input  logic                   pop,
    output logic                   hit,
    output logic [DICT_ADDR_W-1:0] word_addr,
    output logic [DICT_ADDR_W-1:0] next_tib
);

    logic [DICT_ADDR_W-1:0] rd_addr;
    logic [7:0]             rd_data;
    logic                   f_busy;
    logic                   f_done;    // finder end pulse
    logic                   f_hit;
    logic [DICT_ADDR_W-1:0] f_word;
    logic [DICT_ADDR_W-1:0] f_next_tib;

    finder finder_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .tib_in    (tib_in),
        .ctx       (ctx),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (f_busy),
        .done      (f_done),
        .hit       (f_hit),
        .word_addr (f_word),
        .next_tib  (f_next_tib)
    );

    dict_ram ram_inst (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // lane stays taken until the collector has the result
    assign busy = f_busy | f_done | done;

    always_ff @(posedge clk) begin
        if (reset)       done <= 1'b0;
        else if (f_done) done <= 1'b1;
        else if (pop)    done <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (f_done) begin
            hit       <= f_hit;       // held until the next search ends
            word_addr <= f_word;
            next_tib  <= f_next_tib;
        end
    end

endmodule
